/* id_decode.f */
src/mips_isa_pkg.sv
src/decode_pkg.sv
src/instr_fields_if.sv
src/alu_ctrl_dec.sv
src/main_ctrl_dec.sv
src/branch_cond_dec.sv
src/operand_use_dec.sv
src/hilo_excp_dec.sv
src/id_decode.sv
verif/id_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the decoder testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module id_decode_tb -f id_decode.f \
	-o id_decode_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/id_decode_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/id_decode_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module id_decode_tb;

	// vectors per test, in run order
	localparam int max_vectors = 18 + 21 + 12 + 13 + 10 + 12;
	localparam int timeout_ns = (max_vectors + 10) * 100 + 1000;

	// expected outputs with the flags packed last in port order
	typedef struct packed {
		logic [4:0] alu;
		logic [4:0] wreg;
		logic [1:0] dst;
		logic [2:0] bc;
		logic rw, imm, m2r, mr, mw, rsv, mfc, rrs, rrt, se;
		logic c0w, c0r, er, brk, sys, hr, hw, dm, si;
	} ctrl_t;

	logic clk = 1'b0;
	logic reset;
	logic [31:0] instr;
	logic [31:0] instr_next;
	decode_pkg::alu_ctrl_e alu_control;
	logic [4:0] write_reg;
	decode_pkg::reg_dst_e reg_dst;
	decode_pkg::branch_cond_e branch_cond;
	logic reg_write, is_imm, mem_to_reg, mem_read, mem_write, reserved_instr, is_mfc;
	logic read_rs, read_rt, sign_ext, cp0_write, cp0_read, eret, break_excp, syscall;
	logic hilo_read, hilo_write, div_mul_en, single_issue;

	logic [31:0] rng_state = 32'h5aa3;
	string cur_test;
	int vec_count = 0;

	id_decode dut_i (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] op_word(input logic [5:0] op);
		logic [31:0] r;
		r = lcg_next();
		return {op, r[25:0]};
	endfunction

	function automatic logic [31:0] special_word(input logic [5:0] op, input logic [5:0] fn);
		logic [31:0] r;
		r = lcg_next();
		return {op, r[25:6], fn};
	endfunction

	function automatic logic [31:0] regimm_word(input logic [4:0] rt);
		logic [31:0] r;
		r = lcg_next();
		return {6'h01, r[25:21], rt, r[15:0]};
	endfunction

	function automatic logic [31:0] cop0_word(input logic [4:0] rs);
		logic [31:0] r;
		r = lcg_next();
		return {6'h10, rs, r[20:0]};
	endfunction

	function automatic logic [31:0] next_word();
		return lcg_next() | 32'h1;
	endfunction

	function automatic ctrl_t ref_model(input logic [31:0] ins, input logic [31:0] nxt);
		ctrl_t r;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		op = ins[31:26];
		fn = ins[5:0];
		rs = ins[25:21];
		rt = ins[20:16];
		r = '0;
		r.alu = decode_pkg::alu_nop;
		r.wreg = ins[15:11];
		r.dst = decode_pkg::dst_rd;
		r.bc = decode_pkg::bc_none;
		// andi, ori, xori and lui zero-extend
		r.se = !(op inside {6'h0c, 6'h0d, 6'h0e, 6'h0f});
		case (op)
			6'h00: begin
				case (fn)
					6'h20: r.alu = decode_pkg::alu_add;
					6'h21: r.alu = decode_pkg::alu_addu;
					6'h22: r.alu = decode_pkg::alu_sub;
					6'h23: r.alu = decode_pkg::alu_subu;
					6'h24: r.alu = decode_pkg::alu_and;
					6'h25: r.alu = decode_pkg::alu_or;
					6'h26: r.alu = decode_pkg::alu_xor;
					6'h27: r.alu = decode_pkg::alu_nor;
					6'h2a: r.alu = decode_pkg::alu_slt;
					6'h2b: r.alu = decode_pkg::alu_sltu;
					6'h00: r.alu = decode_pkg::alu_sll;
					6'h02: r.alu = decode_pkg::alu_srl;
					6'h03: r.alu = decode_pkg::alu_sra;
					6'h04: r.alu = decode_pkg::alu_sllv;
					6'h06: r.alu = decode_pkg::alu_srlv;
					6'h07: r.alu = decode_pkg::alu_srav;
					6'h0b: r.alu = decode_pkg::alu_movn;
					6'h0a: r.alu = decode_pkg::alu_movz;
					6'h10: r.alu = decode_pkg::alu_mfhi;
					6'h12: r.alu = decode_pkg::alu_mflo;
					default: r.alu = decode_pkg::alu_nop;
				endcase
				case (fn)
					6'h00, 6'h02, 6'h03: begin
						r.rw = 1'b1;
						r.rrt = 1'b1;
					end
					6'h04, 6'h06, 6'h07, 6'h0a, 6'h0b, 6'h20, 6'h21, 6'h22, 6'h23,
					6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: begin
						r.rw = 1'b1;
						r.rrs = 1'b1;
						r.rrt = 1'b1;
					end
					6'h10, 6'h12: begin
						r.rw = 1'b1;
						r.hr = 1'b1;
					end
					6'h11, 6'h13: begin
						r.rrs = 1'b1;
						r.hw = 1'b1;
						r.si = 1'b1;
					end
					6'h18, 6'h19, 6'h1a, 6'h1b: begin
						r.rrs = 1'b1;
						r.rrt = 1'b1;
						r.hw = 1'b1;
						r.dm = 1'b1;
						r.si = 1'b1;
					end
					6'h08: r.rrs = 1'b1;
					6'h09: begin
						r.rw = 1'b1;
						r.rrs = 1'b1;
						r.dst = decode_pkg::dst_ra;
						r.wreg = 5'd31;
					end
					6'h0c: r.sys = 1'b1;
					6'h0d: r.brk = 1'b1;
					// unknown funct is reserved but still writes rd
					default: begin
						r.rw = 1'b1;
						r.rsv = 1'b1;
					end
				endcase
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				r.rw = 1'b1;
				r.dst = decode_pkg::dst_rt;
				r.imm = 1'b1;
				r.wreg = rt;
				r.rrs = op != 6'h0f;
				case (op[2:0])
					3'd0: r.alu = decode_pkg::alu_add;
					3'd1: r.alu = decode_pkg::alu_addu;
					3'd2: r.alu = decode_pkg::alu_slt;
					3'd3: r.alu = decode_pkg::alu_sltu;
					3'd4: r.alu = decode_pkg::alu_and;
					3'd5: r.alu = decode_pkg::alu_or;
					3'd6: r.alu = decode_pkg::alu_xor;
					default: r.alu = decode_pkg::alu_lui;
				endcase
			end
			6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h30: begin
				r.rw = 1'b1;
				r.dst = decode_pkg::dst_rt;
				r.imm = 1'b1;
				r.wreg = rt;
				r.m2r = 1'b1;
				r.mr = 1'b1;
				r.alu = decode_pkg::alu_addu;
				r.rrs = 1'b1;
				r.si = 1'b1;
			end
			6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e: begin
				r.imm = 1'b1;
				r.mw = 1'b1;
				r.alu = decode_pkg::alu_addu;
				r.rrs = 1'b1;
				r.rrt = 1'b1;
				r.si = 1'b1;
			end
			6'h04, 6'h05: begin
				r.bc = (op == 6'h04) ? decode_pkg::bc_eq : decode_pkg::bc_ne;
				r.rrs = 1'b1;
				r.rrt = 1'b1;
			end
			6'h06, 6'h07: begin
				r.bc = (op == 6'h06) ? decode_pkg::bc_lez : decode_pkg::bc_gtz;
				r.rrs = 1'b1;
			end
			6'h02: r.rw = 1'b0;
			6'h03: begin
				r.rw = 1'b1;
				r.dst = decode_pkg::dst_ra;
				r.wreg = 5'd31;
			end
			6'h01: begin
				r.bc = (rt == 5'd1 || rt == 5'd17) ? decode_pkg::bc_gez : decode_pkg::bc_ltz;
				case (rt)
					5'd0, 5'd1: r.rrs = 1'b1;
					5'd16, 5'd17: begin
						r.rrs = 1'b1;
						r.rw = 1'b1;
						r.dst = decode_pkg::dst_ra;
						r.wreg = 5'd31;
					end
					default: r.rsv = 1'b1;
				endcase
			end
			6'h10: begin
				case (rs)
					5'd4: begin
						r.alu = decode_pkg::alu_mtc0;
						r.c0w = 1'b1;
						r.rrt = 1'b1;
						r.si = 1'b1;
					end
					5'd0: begin
						r.alu = decode_pkg::alu_mfc0;
						r.rw = 1'b1;
						r.dst = decode_pkg::dst_rt;
						r.wreg = rt;
						r.mfc = 1'b1;
						r.c0r = 1'b1;
					end
					default: begin
						// only the exact eret word is legal
						r.rsv = ins != 32'h42000018;
						r.er = rs == 5'd16;
					end
				endcase
			end
			default: r.rsv = 1'b1;
		endcase
		if (ins == 32'h0) begin
			r.rw = 1'b0;
			r.imm = 1'b0;
			r.m2r = 1'b0;
			r.mr = 1'b0;
			r.mw = 1'b0;
			r.rrs = 1'b0;
			r.rrt = 1'b0;
			r.dst = decode_pkg::dst_rd;
			r.alu = decode_pkg::alu_nop;
		end
		if (nxt == 32'h0) begin
			r.si = 1'b0;
		end
		return r;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch in %s on %s (instr %h): expected %h, actual %h",
				cur_test, what, instr, exp, act);
			$display("Simulation failed");
			$fatal(1, "first error, run stopped");
		end
	endtask

	task automatic apply_and_check(input logic [31:0] ins, input logic [31:0] nxt);
		ctrl_t exp;
		logic [18:0] act_flags;
		@(negedge clk);
		instr = ins;
		instr_next = nxt;
		@(posedge clk);
		exp = ref_model(ins, nxt);
		act_flags = {reg_write, is_imm, mem_to_reg, mem_read, mem_write, reserved_instr,
			is_mfc, read_rs, read_rt, sign_ext, cp0_write, cp0_read, eret, break_excp,
			syscall, hilo_read, hilo_write, div_mul_en, single_issue};
		check_equal("alu_control", 32'(exp.alu), 32'(alu_control));
		check_equal("write_reg", 32'(exp.wreg), 32'(write_reg));
		check_equal("reg_dst", 32'(exp.dst), 32'(reg_dst));
		check_equal("branch_cond", 32'(exp.bc), 32'(branch_cond));
		check_equal("flags", 32'(exp[18:0]), 32'(act_flags));
		vec_count++;
	endtask

	task automatic r_alu_decode();
		logic [5:0] functs [18];
		int i;
		cur_test = "r_alu";
		functs = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
			6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h0a, 6'h0b};
		for (i = 0; i < 18; i++) begin
			apply_and_check(special_word(6'h00, functs[i]), next_word());
			check_equal("reg_write", 32'd1, 32'(reg_write));
		end
	endtask

	task automatic imm_mem_decode();
		logic [5:0] ops [21];
		int i;
		cur_test = "imm_mem";
		ops = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
			6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h30,
			6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e};
		for (i = 0; i < 21; i++) begin
			apply_and_check(op_word(ops[i]), next_word());
		end
	endtask

	task automatic branch_jump_decode();
		cur_test = "branch_jump";
		apply_and_check(op_word(6'h04), next_word());
		apply_and_check(op_word(6'h05), next_word());
		apply_and_check(op_word(6'h06), next_word());
		apply_and_check(op_word(6'h07), next_word());
		apply_and_check(regimm_word(5'd0), next_word());
		apply_and_check(regimm_word(5'd1), next_word());
		// and-link forms
		apply_and_check(regimm_word(5'd16), next_word());
		apply_and_check(regimm_word(5'd17), next_word());
		apply_and_check(op_word(6'h02), next_word());
		apply_and_check(op_word(6'h03), next_word());
		apply_and_check(special_word(6'h00, 6'h08), next_word());
		apply_and_check(special_word(6'h00, 6'h09), next_word());
	endtask

	task automatic hilo_cop0_decode();
		logic [5:0] functs [10];
		int i;
		cur_test = "hilo_cop0";
		functs = '{6'h10, 6'h12, 6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h0c, 6'h0d};
		for (i = 0; i < 10; i++) begin
			apply_and_check(special_word(6'h00, functs[i]), next_word());
		end
		apply_and_check(cop0_word(5'd4), next_word());
		apply_and_check(cop0_word(5'd0), next_word());
		apply_and_check(32'h42000018, next_word());
	endtask

	task automatic reserved_decode();
		cur_test = "reserved";
		// mul, clz, seb, ext
		apply_and_check(special_word(6'h1c, 6'h02), next_word());
		apply_and_check(special_word(6'h1c, 6'h20), next_word());
		apply_and_check(special_word(6'h1f, 6'h20), next_word());
		apply_and_check(special_word(6'h1f, 6'h00), next_word());
		// teq keeps the rd write
		apply_and_check(special_word(6'h00, 6'h34), next_word());
		check_equal("reg_write", 32'd1, 32'(reg_write));
		apply_and_check(regimm_word(5'd8), next_word());
		apply_and_check(op_word(6'h3b), next_word());
		check_equal("reserved_instr", 32'd1, 32'(reserved_instr));
		apply_and_check(32'h42000001, next_word());
		apply_and_check(32'h42000018, next_word());
		check_equal("reserved_instr", 32'd0, 32'(reserved_instr));
		apply_and_check(32'h0, next_word());
	endtask

	task automatic single_issue_gating();
		logic [31:0] words [6];
		logic serial [6];
		logic [31:0] nxt;
		int i;
		int k;
		cur_test = "single_issue";
		words = '{op_word(6'h23), op_word(6'h28), cop0_word(5'd4),
			special_word(6'h00, 6'h18), special_word(6'h00, 6'h20), op_word(6'h0d)};
		serial = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
		for (i = 0; i < 6; i++) begin
			for (k = 0; k < 2; k++) begin
				nxt = (k == 0) ? next_word() : 32'h0;
				apply_and_check(words[i], nxt);
				check_equal("single_issue", 32'(serial[i] && nxt != 32'h0),
					32'(single_issue));
			end
		end
	endtask

	initial begin
		#(timeout_ns);
		$display("timeout: decode tests did not finish after %0d vectors", vec_count);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		instr = '0;
		instr_next = '0;
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		r_alu_decode();
		imm_mem_decode();
		branch_jump_decode();
		hilo_cop0_decode();
		reserved_decode();
		single_issue_gating();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* src/id_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module id_decode (
	input wire [mips_isa_pkg::instr_w-1:0] instr,
	input wire [mips_isa_pkg::instr_w-1:0] instr_next,
	output decode_pkg::alu_ctrl_e alu_control,
	output logic [mips_isa_pkg::reg_addr_w-1:0] write_reg,
	output decode_pkg::reg_dst_e reg_dst,
	output decode_pkg::branch_cond_e branch_cond,
	output logic reg_write,
	output logic is_imm,
	output logic mem_to_reg,
	output logic mem_read,
	output logic mem_write,
	output logic reserved_instr,
	output logic is_mfc,
	output logic read_rs,
	output logic read_rt,
	output logic sign_ext,
	output logic cp0_write,
	output logic cp0_read,
	output logic eret,
	output logic break_excp,
	output logic syscall,
	output logic hilo_read,
	output logic hilo_write,
	output logic div_mul_en,
	output logic single_issue
);

	instr_fields_if fields_if ();

	// field split
	assign fields_if.instr = instr;
	assign fields_if.op = instr[31:26];
	assign fields_if.rs = instr[25:21];
	assign fields_if.rt = instr[20:16];
	assign fields_if.rd = instr[15:11];
	assign fields_if.shamt = instr[10:6];
	assign fields_if.funct = instr[5:0];

	main_ctrl_dec main_ctrl_dec_i (
		.fields(fields_if),
		.alu_control(alu_control),
		.write_reg(write_reg),
		.reg_write(reg_write),
		.reg_dst(reg_dst),
		.is_imm(is_imm),
		.mem_to_reg(mem_to_reg),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reserved_instr(reserved_instr),
		.is_mfc(is_mfc)
	);

	branch_cond_dec branch_cond_dec_i (
		.fields(fields_if),
		.branch_cond(branch_cond)
	);

	operand_use_dec operand_use_dec_i (
		.fields(fields_if),
		.read_rs(read_rs),
		.read_rt(read_rt)
	);

	hilo_excp_dec hilo_excp_dec_i (
		.fields(fields_if),
		.instr_next(instr_next),
		.sign_ext(sign_ext),
		.cp0_write(cp0_write),
		.cp0_read(cp0_read),
		.eret(eret),
		.break_excp(break_excp),
		.syscall(syscall),
		.hilo_read(hilo_read),
		.hilo_write(hilo_write),
		.div_mul_en(div_mul_en),
		.single_issue(single_issue)
	);

endmodule

`default_nettype wire

/* src/hilo_excp_dec.sv */
`timescale 1ns/100ps
`default_nettype none

module hilo_excp_dec (
	instr_fields_if.dec fields,
	input wire [mips_isa_pkg::instr_w-1:0] instr_next,
	output logic sign_ext,
	output logic cp0_write,
	output logic cp0_read,
	output logic eret,
	output logic break_excp,
	output logic syscall,
	output logic hilo_read,
	output logic hilo_write,
	output logic div_mul_en,
	output logic single_issue
);

	logic is_r_type;
	logic is_cop0;

	assign is_r_type = fields.op == mips_isa_pkg::op_r_type;
	assign is_cop0 = fields.op == mips_isa_pkg::op_cop0;

	// andi, ori, xori and lui zero-extend
	assign sign_ext = fields.op[5:2] != 4'b0011;

	assign cp0_write = is_cop0 && fields.rs == mips_isa_pkg::cop0_mtc0;
	assign cp0_read = is_cop0 && fields.rs == mips_isa_pkg::cop0_mfc0;
	assign eret = is_cop0 && fields.rs == mips_isa_pkg::cop0_co;

	assign break_excp = is_r_type && fields.funct == mips_isa_pkg::fn_break;
	assign syscall = is_r_type && fields.funct == mips_isa_pkg::fn_syscall;

	always_comb begin
		div_mul_en = 1'b0;
		hilo_read = 1'b0;
		hilo_write = 1'b0;
		case (fields.funct)
			mips_isa_pkg::fn_mult, mips_isa_pkg::fn_multu, mips_isa_pkg::fn_div,
			mips_isa_pkg::fn_divu: begin
				div_mul_en = is_r_type;
				hilo_write = is_r_type;
			end
			mips_isa_pkg::fn_mthi, mips_isa_pkg::fn_mtlo: hilo_write = is_r_type;
			mips_isa_pkg::fn_mfhi, mips_isa_pkg::fn_mflo: hilo_read = is_r_type;
			default: hilo_read = 1'b0;
		endcase
	end

	// these block dual issue with the partner slot
	always_comb begin
		case (fields.op)
			mips_isa_pkg::op_r_type: single_issue = hilo_write;
			mips_isa_pkg::op_lw, mips_isa_pkg::op_lb, mips_isa_pkg::op_lbu,
			mips_isa_pkg::op_lh, mips_isa_pkg::op_lhu, mips_isa_pkg::op_lwl,
			mips_isa_pkg::op_lwr, mips_isa_pkg::op_ll, mips_isa_pkg::op_sw,
			mips_isa_pkg::op_sb, mips_isa_pkg::op_sh, mips_isa_pkg::op_swl,
			mips_isa_pkg::op_swr: single_issue = 1'b1;
			mips_isa_pkg::op_cop0: single_issue = cp0_write;
			default: single_issue = 1'b0;
		endcase
		// nothing to pair with
		if (instr_next == '0) begin
			single_issue = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/operand_use_dec.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_use_dec (
	instr_fields_if.dec fields,
	output logic read_rs,
	output logic read_rt
);

	always_comb begin
		read_rs = 1'b0;
		read_rt = 1'b0;
		case (fields.op)
			mips_isa_pkg::op_r_type: begin
				case (fields.funct)
					mips_isa_pkg::fn_add, mips_isa_pkg::fn_addu, mips_isa_pkg::fn_sub,
					mips_isa_pkg::fn_subu, mips_isa_pkg::fn_and, mips_isa_pkg::fn_or,
					mips_isa_pkg::fn_xor, mips_isa_pkg::fn_nor, mips_isa_pkg::fn_slt,
					mips_isa_pkg::fn_sltu, mips_isa_pkg::fn_sllv, mips_isa_pkg::fn_srlv,
					mips_isa_pkg::fn_srav, mips_isa_pkg::fn_movn, mips_isa_pkg::fn_movz,
					mips_isa_pkg::fn_mult, mips_isa_pkg::fn_multu, mips_isa_pkg::fn_div,
					mips_isa_pkg::fn_divu: begin
						read_rs = 1'b1;
						read_rt = 1'b1;
					end
					// shift amount comes from shamt
					mips_isa_pkg::fn_sll, mips_isa_pkg::fn_srl, mips_isa_pkg::fn_sra: begin
						read_rt = 1'b1;
					end
					mips_isa_pkg::fn_jr, mips_isa_pkg::fn_jalr, mips_isa_pkg::fn_mthi,
					mips_isa_pkg::fn_mtlo: begin
						read_rs = 1'b1;
					end
					default: read_rs = 1'b0;
				endcase
			end
			mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti,
			mips_isa_pkg::op_sltiu, mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
			mips_isa_pkg::op_xori, mips_isa_pkg::op_blez, mips_isa_pkg::op_bgtz,
			mips_isa_pkg::op_lw, mips_isa_pkg::op_lb, mips_isa_pkg::op_lbu,
			mips_isa_pkg::op_lh, mips_isa_pkg::op_lhu, mips_isa_pkg::op_lwl,
			mips_isa_pkg::op_lwr, mips_isa_pkg::op_ll: begin
				read_rs = 1'b1;
			end
			mips_isa_pkg::op_beq, mips_isa_pkg::op_bne, mips_isa_pkg::op_sw,
			mips_isa_pkg::op_sb, mips_isa_pkg::op_sh, mips_isa_pkg::op_swl,
			mips_isa_pkg::op_swr: begin
				read_rs = 1'b1;
				read_rt = 1'b1;
			end
			mips_isa_pkg::op_regimm: begin
				case (fields.rt)
					mips_isa_pkg::ri_bltz, mips_isa_pkg::ri_bgez, mips_isa_pkg::ri_bltzal,
					mips_isa_pkg::ri_bgezal: read_rs = 1'b1;
					default: read_rs = 1'b0;
				endcase
			end
			// mtc0 moves gpr rt into cp0
			mips_isa_pkg::op_cop0: read_rt = fields.rs == mips_isa_pkg::cop0_mtc0;
			default: read_rs = 1'b0;
		endcase

		if (fields.instr == '0) begin
			read_rs = 1'b0;
			read_rt = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/branch_cond_dec.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_cond_dec (
	instr_fields_if.dec fields,
	output decode_pkg::branch_cond_e branch_cond
);

	always_comb begin
		case (fields.op)
			mips_isa_pkg::op_beq: branch_cond = decode_pkg::bc_eq;
			mips_isa_pkg::op_bne: branch_cond = decode_pkg::bc_ne;
			mips_isa_pkg::op_blez: branch_cond = decode_pkg::bc_lez;
			mips_isa_pkg::op_bgtz: branch_cond = decode_pkg::bc_gtz;
			mips_isa_pkg::op_regimm: begin
				// unknown rt falls back to ltz, reserved flag covers it
				case (fields.rt)
					mips_isa_pkg::ri_bgez, mips_isa_pkg::ri_bgezal: begin
						branch_cond = decode_pkg::bc_gez;
					end
					default: branch_cond = decode_pkg::bc_ltz;
				endcase
			end
			default: branch_cond = decode_pkg::bc_none;
		endcase
	end

endmodule

`default_nettype wire

/* src/main_ctrl_dec.sv */
`timescale 1ns/100ps
`default_nettype none

module main_ctrl_dec (
	instr_fields_if.dec fields,
	output decode_pkg::alu_ctrl_e alu_control,
	output logic [mips_isa_pkg::reg_addr_w-1:0] write_reg,
	output logic reg_write,
	output decode_pkg::reg_dst_e reg_dst,
	output logic is_imm,
	output logic mem_to_reg,
	output logic mem_read,
	output logic mem_write,
	output logic reserved_instr,
	output logic is_mfc
);

	decode_pkg::alu_op_e alu_op;

	alu_ctrl_dec alu_ctrl_dec_i (
		.alu_op(alu_op),
		.funct(fields.funct),
		.alu_control(alu_control)
	);

	always_comb begin
		alu_op = decode_pkg::aluop_none;
		write_reg = fields.rd;
		reg_write = 1'b0;
		reg_dst = decode_pkg::dst_rd;
		is_imm = 1'b0;
		mem_to_reg = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reserved_instr = 1'b0;
		is_mfc = 1'b0;

		case (fields.op)
			mips_isa_pkg::op_r_type: begin
				case (fields.funct)
					mips_isa_pkg::fn_add, mips_isa_pkg::fn_addu, mips_isa_pkg::fn_sub,
					mips_isa_pkg::fn_subu, mips_isa_pkg::fn_and, mips_isa_pkg::fn_or,
					mips_isa_pkg::fn_xor, mips_isa_pkg::fn_nor, mips_isa_pkg::fn_slt,
					mips_isa_pkg::fn_sltu, mips_isa_pkg::fn_sll, mips_isa_pkg::fn_srl,
					mips_isa_pkg::fn_sra, mips_isa_pkg::fn_sllv, mips_isa_pkg::fn_srlv,
					mips_isa_pkg::fn_srav, mips_isa_pkg::fn_movn, mips_isa_pkg::fn_movz,
					mips_isa_pkg::fn_mfhi, mips_isa_pkg::fn_mflo: begin
						alu_op = decode_pkg::aluop_r_type;
						reg_write = 1'b1;
					end
					// no gpr result
					mips_isa_pkg::fn_jr, mips_isa_pkg::fn_mult, mips_isa_pkg::fn_multu,
					mips_isa_pkg::fn_div, mips_isa_pkg::fn_divu, mips_isa_pkg::fn_mthi,
					mips_isa_pkg::fn_mtlo, mips_isa_pkg::fn_syscall,
					mips_isa_pkg::fn_break: begin
						alu_op = decode_pkg::aluop_r_type;
					end
					mips_isa_pkg::fn_jalr: begin
						alu_op = decode_pkg::aluop_r_type;
						reg_write = 1'b1;
						reg_dst = decode_pkg::dst_ra;
						write_reg = mips_isa_pkg::ra_reg;
					end
					// unknown funct still claims rd
					default: begin
						reserved_instr = 1'b1;
						reg_write = 1'b1;
					end
				endcase
			end
			mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti,
			mips_isa_pkg::op_sltiu, mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
			mips_isa_pkg::op_xori, mips_isa_pkg::op_lui: begin
				reg_write = 1'b1;
				reg_dst = decode_pkg::dst_rt;
				is_imm = 1'b1;
				write_reg = fields.rt;
				case (fields.op)
					mips_isa_pkg::op_addi: alu_op = decode_pkg::aluop_addi;
					mips_isa_pkg::op_addiu: alu_op = decode_pkg::aluop_addiu;
					mips_isa_pkg::op_slti: alu_op = decode_pkg::aluop_slti;
					mips_isa_pkg::op_sltiu: alu_op = decode_pkg::aluop_sltiu;
					mips_isa_pkg::op_andi: alu_op = decode_pkg::aluop_andi;
					mips_isa_pkg::op_ori: alu_op = decode_pkg::aluop_ori;
					mips_isa_pkg::op_xori: alu_op = decode_pkg::aluop_xori;
					default: alu_op = decode_pkg::aluop_lui;
				endcase
			end
			mips_isa_pkg::op_lw, mips_isa_pkg::op_lb, mips_isa_pkg::op_lbu,
			mips_isa_pkg::op_lh, mips_isa_pkg::op_lhu, mips_isa_pkg::op_lwl,
			mips_isa_pkg::op_lwr, mips_isa_pkg::op_ll: begin
				alu_op = decode_pkg::aluop_mem;
				reg_write = 1'b1;
				reg_dst = decode_pkg::dst_rt;
				is_imm = 1'b1;
				write_reg = fields.rt;
				mem_to_reg = 1'b1;
				mem_read = 1'b1;
			end
			mips_isa_pkg::op_sw, mips_isa_pkg::op_sb, mips_isa_pkg::op_sh,
			mips_isa_pkg::op_swl, mips_isa_pkg::op_swr: begin
				alu_op = decode_pkg::aluop_mem;
				is_imm = 1'b1;
				mem_write = 1'b1;
			end
			mips_isa_pkg::op_beq, mips_isa_pkg::op_bne, mips_isa_pkg::op_blez,
			mips_isa_pkg::op_bgtz, mips_isa_pkg::op_j: begin
				alu_op = decode_pkg::aluop_none;
			end
			mips_isa_pkg::op_regimm: begin
				case (fields.rt)
					mips_isa_pkg::ri_bltzal, mips_isa_pkg::ri_bgezal: begin
						reg_write = 1'b1;
						reg_dst = decode_pkg::dst_ra;
						write_reg = mips_isa_pkg::ra_reg;
					end
					mips_isa_pkg::ri_bltz, mips_isa_pkg::ri_bgez: begin
						reg_write = 1'b0;
					end
					default: reserved_instr = 1'b1;
				endcase
			end
			mips_isa_pkg::op_jal: begin
				reg_write = 1'b1;
				reg_dst = decode_pkg::dst_ra;
				write_reg = mips_isa_pkg::ra_reg;
			end
			mips_isa_pkg::op_cop0: begin
				case (fields.rs)
					mips_isa_pkg::cop0_mtc0: alu_op = decode_pkg::aluop_mtc0;
					mips_isa_pkg::cop0_mfc0: begin
						alu_op = decode_pkg::aluop_mfc0;
						reg_write = 1'b1;
						reg_dst = decode_pkg::dst_rt;
						write_reg = fields.rt;
						is_mfc = 1'b1;
					end
					// only an exact eret is legal here
					default: reserved_instr = fields.instr[25:0] != mips_isa_pkg::eret_low;
				endcase
			end
			default: reserved_instr = 1'b1;
		endcase

		// nop word
		if (fields.instr == '0) begin
			alu_op = decode_pkg::aluop_none;
			reg_write = 1'b0;
			reg_dst = decode_pkg::dst_rd;
			is_imm = 1'b0;
			mem_to_reg = 1'b0;
			mem_read = 1'b0;
			mem_write = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/alu_ctrl_dec.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_ctrl_dec (
	input wire decode_pkg::alu_op_e alu_op,
	input wire [mips_isa_pkg::funct_w-1:0] funct,
	output decode_pkg::alu_ctrl_e alu_control
);

	always_comb begin
		case (alu_op)
			decode_pkg::aluop_r_type: begin
				case (funct)
					mips_isa_pkg::fn_add: alu_control = decode_pkg::alu_add;
					mips_isa_pkg::fn_addu: alu_control = decode_pkg::alu_addu;
					mips_isa_pkg::fn_sub: alu_control = decode_pkg::alu_sub;
					mips_isa_pkg::fn_subu: alu_control = decode_pkg::alu_subu;
					mips_isa_pkg::fn_and: alu_control = decode_pkg::alu_and;
					mips_isa_pkg::fn_or: alu_control = decode_pkg::alu_or;
					mips_isa_pkg::fn_xor: alu_control = decode_pkg::alu_xor;
					mips_isa_pkg::fn_nor: alu_control = decode_pkg::alu_nor;
					mips_isa_pkg::fn_slt: alu_control = decode_pkg::alu_slt;
					mips_isa_pkg::fn_sltu: alu_control = decode_pkg::alu_sltu;
					mips_isa_pkg::fn_sll: alu_control = decode_pkg::alu_sll;
					mips_isa_pkg::fn_srl: alu_control = decode_pkg::alu_srl;
					mips_isa_pkg::fn_sra: alu_control = decode_pkg::alu_sra;
					mips_isa_pkg::fn_sllv: alu_control = decode_pkg::alu_sllv;
					mips_isa_pkg::fn_srlv: alu_control = decode_pkg::alu_srlv;
					mips_isa_pkg::fn_srav: alu_control = decode_pkg::alu_srav;
					mips_isa_pkg::fn_movn: alu_control = decode_pkg::alu_movn;
					mips_isa_pkg::fn_movz: alu_control = decode_pkg::alu_movz;
					mips_isa_pkg::fn_mfhi: alu_control = decode_pkg::alu_mfhi;
					mips_isa_pkg::fn_mflo: alu_control = decode_pkg::alu_mflo;
					// jumps, mul/div, hi/lo writes and traps use no alu
					default: alu_control = decode_pkg::alu_nop;
				endcase
			end
			decode_pkg::aluop_addi: alu_control = decode_pkg::alu_add;
			decode_pkg::aluop_addiu: alu_control = decode_pkg::alu_addu;
			decode_pkg::aluop_slti: alu_control = decode_pkg::alu_slt;
			decode_pkg::aluop_sltiu: alu_control = decode_pkg::alu_sltu;
			decode_pkg::aluop_andi: alu_control = decode_pkg::alu_and;
			decode_pkg::aluop_ori: alu_control = decode_pkg::alu_or;
			decode_pkg::aluop_xori: alu_control = decode_pkg::alu_xor;
			decode_pkg::aluop_lui: alu_control = decode_pkg::alu_lui;
			// address calc, base plus offset
			decode_pkg::aluop_mem: alu_control = decode_pkg::alu_addu;
			decode_pkg::aluop_mtc0: alu_control = decode_pkg::alu_mtc0;
			decode_pkg::aluop_mfc0: alu_control = decode_pkg::alu_mfc0;
			default: alu_control = decode_pkg::alu_nop;
		endcase
	end

endmodule

`default_nettype wire

/* src/instr_fields_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface instr_fields_if;

	logic [mips_isa_pkg::instr_w-1:0] instr;
	logic [mips_isa_pkg::op_w-1:0] op;
	logic [mips_isa_pkg::funct_w-1:0] funct;
	logic [mips_isa_pkg::reg_addr_w-1:0] rs;
	logic [mips_isa_pkg::reg_addr_w-1:0] rt;
	logic [mips_isa_pkg::reg_addr_w-1:0] rd;
	logic [mips_isa_pkg::reg_addr_w-1:0] shamt;

	// slicing side
	modport src (output instr, op, funct, rs, rt, rd, shamt);

	// decoder side
	modport dec (input instr, op, funct, rs, rt, rd, shamt);

endinterface

`default_nettype wire

/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	// class of operation handed from the main decoder to the alu decoder
	typedef enum logic [3:0] {
		aluop_r_type,
		aluop_addi,
		aluop_addiu,
		aluop_slti,
		aluop_sltiu,
		aluop_andi,
		aluop_ori,
		aluop_xori,
		aluop_lui,
		aluop_mem,
		aluop_mtc0,
		aluop_mfc0,
		aluop_none
	} alu_op_e;

	typedef enum logic [4:0] {
		alu_add,
		alu_addu,
		alu_sub,
		alu_subu,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_sllv,
		alu_srlv,
		alu_srav,
		alu_movn,
		alu_movz,
		alu_mfhi,
		alu_mflo,
		alu_lui,
		alu_mtc0,
		alu_mfc0,
		alu_nop
	} alu_ctrl_e;

	// comparison done by the branch unit
	typedef enum logic [2:0] {
		bc_none = 3'd0,
		bc_eq   = 3'd1,
		bc_ne   = 3'd2,
		bc_lez  = 3'd3,
		bc_gtz  = 3'd4,
		bc_ltz  = 3'd5,
		bc_gez  = 3'd6
	} branch_cond_e;

	typedef enum logic [1:0] {
		dst_rd = 2'd0,
		dst_rt = 2'd1,
		dst_ra = 2'd2
	} reg_dst_e;

endpackage

`default_nettype wire

/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	localparam int unsigned instr_w = 32;
	localparam int unsigned op_w = 6;
	localparam int unsigned funct_w = 6;
	localparam int unsigned reg_addr_w = 5;

	// link target of jal, jalr and the and-link branches
	localparam logic [reg_addr_w-1:0] ra_reg = 5'd31;

	// eret is cop0 with the co bit and funct 6'h18
	localparam logic [25:0] eret_low = 26'h2000018;

	typedef enum logic [op_w-1:0] {
		op_r_type = 6'b000000,
		op_regimm = 6'b000001,
		op_j      = 6'b000010,
		op_jal    = 6'b000011,
		op_beq    = 6'b000100,
		op_bne    = 6'b000101,
		op_blez   = 6'b000110,
		op_bgtz   = 6'b000111,
		op_addi   = 6'b001000,
		op_addiu  = 6'b001001,
		op_slti   = 6'b001010,
		op_sltiu  = 6'b001011,
		op_andi   = 6'b001100,
		op_ori    = 6'b001101,
		op_xori   = 6'b001110,
		op_lui    = 6'b001111,
		op_cop0   = 6'b010000,
		op_lb     = 6'b100000,
		op_lh     = 6'b100001,
		op_lwl    = 6'b100010,
		op_lw     = 6'b100011,
		op_lbu    = 6'b100100,
		op_lhu    = 6'b100101,
		op_lwr    = 6'b100110,
		op_sb     = 6'b101000,
		op_sh     = 6'b101001,
		op_swl    = 6'b101010,
		op_sw     = 6'b101011,
		op_swr    = 6'b101110,
		op_ll     = 6'b110000
	} opcode_e;

	typedef enum logic [funct_w-1:0] {
		fn_sll     = 6'h00,
		fn_srl     = 6'h02,
		fn_sra     = 6'h03,
		fn_sllv    = 6'h04,
		fn_srlv    = 6'h06,
		fn_srav    = 6'h07,
		fn_jr      = 6'h08,
		fn_jalr    = 6'h09,
		fn_movz    = 6'h0a,
		fn_movn    = 6'h0b,
		fn_syscall = 6'h0c,
		fn_break   = 6'h0d,
		fn_mfhi    = 6'h10,
		fn_mthi    = 6'h11,
		fn_mflo    = 6'h12,
		fn_mtlo    = 6'h13,
		fn_mult    = 6'h18,
		fn_multu   = 6'h19,
		fn_div     = 6'h1a,
		fn_divu    = 6'h1b,
		fn_add     = 6'h20,
		fn_addu    = 6'h21,
		fn_sub     = 6'h22,
		fn_subu    = 6'h23,
		fn_and     = 6'h24,
		fn_or      = 6'h25,
		fn_xor     = 6'h26,
		fn_nor     = 6'h27,
		fn_slt     = 6'h2a,
		fn_sltu    = 6'h2b
	} funct_e;

	// rt field under regimm
	typedef enum logic [reg_addr_w-1:0] {
		ri_bltz   = 5'b00000,
		ri_bgez   = 5'b00001,
		ri_bltzal = 5'b10000,
		ri_bgezal = 5'b10001
	} regimm_e;

	// rs field under cop0
	typedef enum logic [reg_addr_w-1:0] {
		cop0_mfc0 = 5'b00000,
		cop0_mtc0 = 5'b00100,
		cop0_co   = 5'b10000
	} cop0_rs_e;

endpackage

`default_nettype wire
